//--- mc_row_top.f
mc_pkg.sv
mc_router.sv
mc_vcache.sv
mc_dram_mem.sv
mc_row_top.sv
tb_mc_row.sv

//--- tb_mc_row.sv
// testbench for the row memory system
// clock, reset, directed and random load, store and stat traffic,
// reference memory with a per-column cache model, response assertions

`timescale 1ns/1ns
`default_nettype none

module tb_mc_row import mc_pkg::*; ();

  localparam int n_dir_c     = 6 * num_tiles_x_c;
  localparam int n_rand_c    = 300;
  localparam int n_tags_c    = 1 << tag_id_width_c;
  localparam int wd_cycles_c = (n_dir_c + n_rand_c) * 200 + 20;

  logic     clk = 1'b0;
  logic     reset;
  mc_req_s  req_i;
  logic     req_v_i;
  logic     req_ready_o;
  mc_resp_s resp_o;
  logic     resp_v_o;
  logic     resp_ready_i = 1'b1;

  // reference model
  logic [data_width_c-1:0] ref_mem [mem_words_c];
  logic [addr_width_c-1:0] wr_q [$];
  logic                    m_valid [num_tiles_x_c][cache_sets_c];
  logic [tag_width_c-1:0]  m_tag [num_tiles_x_c][cache_sets_c];
  int unsigned             m_hits [num_tiles_x_c];
  int unsigned             m_miss [num_tiles_x_c];
  mc_resp_s                exp_tab [n_tags_c];
  int unsigned             issue_cnt [n_tags_c];
  int unsigned             done_cnt [n_tags_c] = '{default: 0};
  int unsigned             issued_total;
  int unsigned             done_total = 0;
  logic [tag_id_width_c-1:0] next_tag;
  logic                    started;
  logic                    bp_en = 1'b0;

  logic     resp_fire;
  logic     tag_pending;
  mc_resp_s exp_resp;

  mc_row_top mc_row_top_i (
    .clk          (clk),
    .reset        (reset),
    .req_i        (req_i),
    .req_v_i      (req_v_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp_o),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i)
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic value_error(input string sig, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    fail_run($sformatf("error at %0t ns: %s expected 0x%0h got 0x%0h",
                       $time, sig, exp_v, act_v));
  endtask

  // expected response for each tag
  task automatic predict(input mc_op_e op, input logic [addr_width_c-1:0] addr,
                         input logic [data_width_c-1:0] data,
                         input logic [tag_id_width_c-1:0] tag);
    int                     col;
    int                     set;
    logic [tag_width_c-1:0] line_tag;
    mc_resp_s               e;
    col      = int'(addr[x_cord_width_c-1:0]);
    set      = int'(addr[x_cord_width_c +: index_width_c]);
    line_tag = addr[addr_width_c-1 -: tag_width_c];
    e.op     = op;
    e.tag_id = tag;
    e.src_x  = addr[x_cord_width_c-1:0];
    e.hit    = m_valid[col][set] && (m_tag[col][set] == line_tag);
    case (op)
      op_store: begin
        ref_mem[addr] = data;
        wr_q.push_back(addr);
        e.data = data;
        m_valid[col][set] = 1'b1;
        m_tag[col][set]   = line_tag;
      end
      op_load: begin
        e.data = ref_mem[addr];
        if (e.hit) begin
          m_hits[col]++;
        end else begin
          m_miss[col]++;
          m_valid[col][set] = 1'b1;
          m_tag[col][set]   = line_tag;
        end
      end
      default: begin
        e.data = {16'(m_miss[col]), 16'(m_hits[col])};
        e.hit  = 1'b0;
      end
    endcase
    exp_tab[tag] = e;
  endtask

  // holds valid high between back to back requests
  task automatic send_req(input mc_op_e op, input logic [addr_width_c-1:0] addr,
                          input logic [data_width_c-1:0] data);
    logic [tag_id_width_c-1:0] tag;
    @(negedge clk);
    tag = next_tag;
    while (issue_cnt[tag] != done_cnt[tag]) begin
      req_v_i = 1'b0;
      @(negedge clk);
    end
    next_tag = tag + 1'b1;
    predict(op, addr, data, tag);
    issue_cnt[tag]++;
    issued_total++;
    started     = 1'b1;
    req_i.op     = op;
    req_i.addr   = addr;
    req_i.data   = data;
    req_i.tag_id = tag;
    req_v_i      = 1'b1;
    @(posedge clk);
    while (!req_ready_o) @(posedge clk);
  endtask

  always @(negedge clk) begin
    if (bp_en) begin
      resp_ready_i = ($urandom % 3) != 0;
    end else begin
      resp_ready_i = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (reset && resp_v_o && resp_ready_i) begin
      done_cnt[resp_o.tag_id]++;
      done_total++;
    end
  end

  assign resp_fire   = resp_v_o & resp_ready_i;
  assign exp_resp    = exp_tab[resp_o.tag_id];
  assign tag_pending = (issue_cnt[resp_o.tag_id] != done_cnt[resp_o.tag_id]);

  assert property (@(posedge clk) disable iff (!reset) !started |-> req_ready_o && !resp_v_o)
    else fail_run("DUT was not idle after reset before the first request");
  assert property (@(posedge clk) disable iff (!reset) resp_fire |-> tag_pending)
    else fail_run("response came back with a tag_id that has no request outstanding");
  assert property (@(posedge clk) disable iff (!reset) resp_fire |-> resp_o.op == exp_resp.op)
    else value_error("resp_o.op", 32'($sampled(exp_resp.op)), 32'($sampled(resp_o.op)));
  assert property (@(posedge clk) disable iff (!reset)
                   resp_fire |-> resp_o.data == exp_resp.data)
    else value_error("resp_o.data", $sampled(exp_resp.data), $sampled(resp_o.data));
  assert property (@(posedge clk) disable iff (!reset) resp_fire |-> resp_o.hit == exp_resp.hit)
    else value_error("resp_o.hit", 32'($sampled(exp_resp.hit)), 32'($sampled(resp_o.hit)));
  assert property (@(posedge clk) disable iff (!reset)
                   resp_fire |-> resp_o.src_x == exp_resp.src_x)
    else value_error("resp_o.src_x", 32'($sampled(exp_resp.src_x)),
                     32'($sampled(resp_o.src_x)));
  assert property (@(posedge clk) disable iff (!reset)
                   resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o))
    else fail_run("resp_o changed or resp_v_o dropped while resp_ready_i was low");

  initial begin : watchdog
    repeat (wd_cycles_c) @(posedge clk);
    fail_run("timeout, not all responses arrived in time");
  end

  initial begin : stimulus
    logic [addr_width_c-1:0] a;
    int                      pick;
    void'($urandom(32'h8aee));
    reset        = 1'b0;
    req_i        = '0;
    req_v_i      = 1'b0;
    started      = 1'b0;
    next_tag     = '0;
    issued_total = 0;
    for (int c = 0; c < num_tiles_x_c; c++) begin
      m_hits[c] = 0;
      m_miss[c] = 0;
      for (int s = 0; s < cache_sets_c; s++) begin
        m_valid[c][s] = 1'b0;
        m_tag[c][s]   = '0;
      end
    end
    for (int t = 0; t < n_tags_c; t++) begin
      issue_cnt[t] = 0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;
    repeat (3) @(negedge clk);

    // each column sees store, load hit, conflicting store, load miss, load hit and stat
    for (int x = 0; x < num_tiles_x_c; x++) begin
      a = {6'd1, 4'd3, x_cord_width_c'(x)};
      send_req(op_store, a, $urandom);
      send_req(op_load, a, '0);
      send_req(op_store, {6'd2, 4'd3, x_cord_width_c'(x)}, $urandom);
      send_req(op_load, a, '0);
      send_req(op_load, a, '0);
      send_req(op_stat, addr_width_c'(x), '0);
    end

    // small address range so lines conflict
    for (int i = 0; i < n_rand_c; i++) begin
      bp_en = (i >= n_rand_c / 2);
      pick  = $urandom % 10;
      a     = {4'h0, 8'($urandom)};
      if (pick == 0) begin
        send_req(op_stat, a, '0);
      end else if (pick < 5 || wr_q.size() == 0) begin
        send_req(op_store, a, $urandom);
      end else begin
        send_req(op_load, wr_q[$urandom % wr_q.size()], '0);
      end
    end
    @(negedge clk);
    req_v_i = 1'b0;

    while (done_total != issued_total) @(negedge clk);
    bp_en = 1'b0;
    // quiet period for stray responses
    repeat (50) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- mc_row_top.sv
// row top level
// router chain with one vcache bank per column and the shared dram,
// east edge of the last router tied off

`timescale 1ns/1ns
`default_nettype none

module mc_row_top import mc_pkg::*; (
  input  logic     clk,
  input  logic     reset,

  input  mc_req_s  req_i,
  input  logic     req_v_i,
  output logic     req_ready_o,

  output mc_resp_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_ready_i
);

  // link x enters router x from the west
  mc_req_s  req_link        [num_tiles_x_c+1];
  logic     req_v_link      [num_tiles_x_c+1];
  logic     req_ready_link  [num_tiles_x_c+1];
  mc_resp_s resp_link       [num_tiles_x_c+1];
  logic     resp_v_link     [num_tiles_x_c+1];
  logic     resp_ready_link [num_tiles_x_c+1];

  mc_req_s  eject           [num_tiles_x_c];
  logic     eject_v         [num_tiles_x_c];
  logic     eject_ready     [num_tiles_x_c];
  mc_resp_s bank_resp       [num_tiles_x_c];
  logic     bank_resp_v     [num_tiles_x_c];
  logic     bank_resp_ready [num_tiles_x_c];

  mem_req_s                mem_req       [num_tiles_x_c];
  logic                    mem_req_v     [num_tiles_x_c];
  logic                    mem_req_ready [num_tiles_x_c];
  logic                    mem_data_v    [num_tiles_x_c];
  logic [data_width_c-1:0] mem_data;

  // io port on the west
  assign req_link[0]        = req_i;
  assign req_v_link[0]      = req_v_i;
  assign req_ready_o        = req_ready_link[0];
  assign resp_o             = resp_link[0];
  assign resp_v_o           = resp_v_link[0];
  assign resp_ready_link[0] = resp_ready_i;

  // east edge
  assign req_ready_link[num_tiles_x_c] = 1'b1;
  assign resp_link[num_tiles_x_c]      = '0;
  assign resp_v_link[num_tiles_x_c]    = 1'b0;

  for (genvar x = 0; x < num_tiles_x_c; x++) begin : g_col
    mc_router router_i (
      .clk               (clk),
      .reset             (reset),
      .my_x_i            (x_cord_width_c'(x)),
      .req_i             (req_link[x]),
      .req_v_i           (req_v_link[x]),
      .req_ready_o       (req_ready_link[x]),
      .req_o             (req_link[x+1]),
      .req_v_o           (req_v_link[x+1]),
      .req_ready_i       (req_ready_link[x+1]),
      .eject_o           (eject[x]),
      .eject_v_o         (eject_v[x]),
      .eject_ready_i     (eject_ready[x]),
      .bank_resp_i       (bank_resp[x]),
      .bank_resp_v_i     (bank_resp_v[x]),
      .bank_resp_ready_o (bank_resp_ready[x]),
      .east_resp_i       (resp_link[x+1]),
      .east_resp_v_i     (resp_v_link[x+1]),
      .east_resp_ready_o (resp_ready_link[x+1]),
      .resp_o            (resp_link[x]),
      .resp_v_o          (resp_v_link[x]),
      .resp_ready_i      (resp_ready_link[x])
    );

    mc_vcache vcache_i (
      .clk             (clk),
      .reset           (reset),
      .my_x_i          (x_cord_width_c'(x)),
      .req_i           (eject[x]),
      .req_v_i         (eject_v[x]),
      .req_ready_o     (eject_ready[x]),
      .resp_o          (bank_resp[x]),
      .resp_v_o        (bank_resp_v[x]),
      .resp_ready_i    (bank_resp_ready[x]),
      .mem_req_o       (mem_req[x]),
      .mem_req_v_o     (mem_req_v[x]),
      .mem_req_ready_i (mem_req_ready[x]),
      .mem_data_i      (mem_data),
      .mem_data_v_i    (mem_data_v[x])
    );
  end

  mc_dram_mem dram_i (
    .clk             (clk),
    .reset           (reset),
    .mem_req_i       (mem_req),
    .mem_req_v_i     (mem_req_v),
    .mem_req_ready_o (mem_req_ready),
    .mem_data_o      (mem_data),
    .mem_data_v_o    (mem_data_v)
  );

endmodule

`default_nettype wire

//--- mc_dram_mem.sv
// shared dram model
// round-robin grant across the banks, writes done on grant,
// reads return after a fixed latency to the granted bank

`timescale 1ns/1ns
`default_nettype none

module mc_dram_mem import mc_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,

  input  mem_req_s                mem_req_i [num_tiles_x_c],
  input  logic                    mem_req_v_i [num_tiles_x_c],
  output logic                    mem_req_ready_o [num_tiles_x_c],

  output logic [data_width_c-1:0] mem_data_o,
  output logic                    mem_data_v_o [num_tiles_x_c]
);

  typedef enum logic {
    mem_idle,
    mem_read
  } mem_state_e;

  mem_state_e                  state_r;
  logic [data_width_c-1:0]     mem_r [mem_words_c];
  logic [x_cord_width_c-1:0]   rr_ptr_r;
  logic [x_cord_width_c-1:0]   owner_r;
  logic [dram_cnt_width_c-1:0] cnt_r;
  logic [data_width_c-1:0]     rd_data_r;

  logic                        grant_v;
  logic                        grant_fire;
  logic [x_cord_width_c-1:0]   grant_idx;
  mem_req_s                    grant_req;
  logic [addr_width_c-1:0]     grant_addr;

  // first requester at or after the pointer wins
  always_comb begin : arb
    logic [x_cord_width_c-1:0] cand;
    grant_v   = 1'b0;
    grant_idx = rr_ptr_r;
    for (int k = num_tiles_x_c - 1; k >= 0; k--) begin
      cand = rr_ptr_r + x_cord_width_c'(k);
      if (mem_req_v_i[cand]) begin
        grant_v   = 1'b1;
        grant_idx = cand;
      end
    end
  end

  assign grant_fire = (state_r == mem_idle) & grant_v;
  assign grant_req  = mem_req_i[grant_idx];
  // bank id fills the low address bits
  assign grant_addr = {grant_req.addr, grant_idx};
  assign mem_data_o = rd_data_r;

  always_comb begin
    for (int i = 0; i < num_tiles_x_c; i++) begin
      mem_req_ready_o[i] = grant_fire && (grant_idx == x_cord_width_c'(i));
      mem_data_v_o[i]    = (state_r == mem_read) && (cnt_r == '0)
                           && (owner_r == x_cord_width_c'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_r  <= mem_idle;
      rr_ptr_r <= '0;
      cnt_r    <= '0;
    end else begin
      case (state_r)
        mem_idle: begin
          if (grant_fire) begin
            rr_ptr_r <= grant_idx + 1'b1;
            if (!grant_req.write) begin
              state_r <= mem_read;
              cnt_r   <= dram_cnt_width_c'(dram_latency_c - 1);
            end
          end
        end
        mem_read: begin
          if (cnt_r == '0) begin
            state_r <= mem_idle;
          end else begin
            cnt_r <= cnt_r - 1'b1;
          end
        end
        default: state_r <= mem_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (grant_fire) begin
      owner_r <= grant_idx;
      if (grant_req.write) begin
        mem_r[grant_addr] <= grant_req.data;
      end else begin
        rd_data_r <= mem_r[grant_addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- mc_vcache.sv
// vcache bank
// blocking direct-mapped write-through cache, one word per line,
// with load hit and miss counters read back by the stat op

`timescale 1ns/1ns
`default_nettype none

module mc_vcache import mc_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [x_cord_width_c-1:0] my_x_i,

  input  mc_req_s                   req_i,
  input  logic                      req_v_i,
  output logic                      req_ready_o,

  output mc_resp_s                  resp_o,
  output logic                      resp_v_o,
  input  logic                      resp_ready_i,

  output mem_req_s                  mem_req_o,
  output logic                      mem_req_v_o,
  input  logic                      mem_req_ready_i,
  input  logic [data_width_c-1:0]   mem_data_i,
  input  logic                      mem_data_v_i
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_write_through,
    st_fill,
    st_respond
  } cache_state_e;

  cache_state_e state_r;

  logic [tag_width_c-1:0]      tag_mem [cache_sets_c];
  logic [data_width_c-1:0]     data_mem [cache_sets_c];
  logic [cache_sets_c-1:0]     valid_r;

  logic [stat_cnt_width_c-1:0] hit_cnt_r;
  logic [stat_cnt_width_c-1:0] miss_cnt_r;

  mc_req_s                     req_r;
  mc_resp_s                    resp_r;
  logic                        issued_r;

  logic [index_width_c-1:0]    line_idx;
  logic [tag_width_c-1:0]      line_tag;
  logic                        tag_hit;
  logic                        req_fire;
  logic                        fill_done;

  assign line_idx = req_r.addr[x_cord_width_c +: index_width_c];
  assign line_tag = req_r.addr[addr_width_c-1 -: tag_width_c];
  assign tag_hit  = valid_r[line_idx] && (tag_mem[line_idx] == line_tag);

  assign req_ready_o = (state_r == st_idle);
  assign req_fire    = req_v_i & req_ready_o;
  assign fill_done   = (state_r == st_fill) & mem_data_v_i;

  assign resp_o   = resp_r;
  assign resp_v_o = (state_r == st_respond);

  // write-through on stores, one read per load miss
  assign mem_req_v_o = (state_r == st_write_through) | ((state_r == st_fill) & ~issued_r);

  always_comb begin
    mem_req_o.write = (state_r == st_write_through);
    mem_req_o.addr  = req_r.addr[addr_width_c-1:x_cord_width_c];
    mem_req_o.data  = req_r.data;
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state_r    <= st_idle;
      valid_r    <= '0;
      hit_cnt_r  <= '0;
      miss_cnt_r <= '0;
      issued_r   <= 1'b0;
    end else begin
      case (state_r)
        st_idle: begin
          if (req_fire) begin
            state_r <= st_lookup;
          end
        end
        st_lookup: begin
          case (req_r.op)
            op_store: begin
              valid_r[line_idx] <= 1'b1;
              state_r           <= st_write_through;
            end
            op_load: begin
              if (tag_hit) begin
                hit_cnt_r <= hit_cnt_r + 1'b1;
                state_r   <= st_respond;
              end else begin
                miss_cnt_r <= miss_cnt_r + 1'b1;
                state_r    <= st_fill;
              end
            end
            default: state_r <= st_respond;
          endcase
        end
        st_write_through: begin
          if (mem_req_ready_i) begin
            state_r <= st_respond;
          end
        end
        st_fill: begin
          if (mem_req_v_o && mem_req_ready_i) begin
            issued_r <= 1'b1;
          end
          if (fill_done) begin
            issued_r          <= 1'b0;
            valid_r[line_idx] <= 1'b1;
            state_r           <= st_respond;
          end
        end
        st_respond: begin
          if (resp_ready_i) begin
            state_r <= st_idle;
          end
        end
        default: state_r <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_r <= req_i;
    end
    if (state_r == st_lookup) begin
      resp_r.op     <= req_r.op;
      resp_r.tag_id <= req_r.tag_id;
      resp_r.src_x  <= my_x_i;
      resp_r.hit    <= tag_hit && (req_r.op != op_stat);
      case (req_r.op)
        op_stat:  resp_r.data <= {miss_cnt_r, hit_cnt_r};
        op_store: resp_r.data <= req_r.data;
        default:  resp_r.data <= data_mem[line_idx];
      endcase
      if (req_r.op == op_store) begin
        tag_mem[line_idx]  <= line_tag;
        data_mem[line_idx] <= req_r.data;
      end
    end
    // refill from dram
    if (fill_done) begin
      resp_r.data        <= mem_data_i;
      resp_r.hit         <= 1'b0;
      tag_mem[line_idx]  <= line_tag;
      data_mem[line_idx] <= mem_data_i;
    end
  end

endmodule

`default_nettype wire

//--- mc_router.sv
// row router
// one-entry request stage steering east or south by column,
// one-entry response stage merging bank and east traffic westward

`timescale 1ns/1ns
`default_nettype none

module mc_router import mc_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [x_cord_width_c-1:0] my_x_i,

  // requests from the west
  input  mc_req_s                   req_i,
  input  logic                      req_v_i,
  output logic                      req_ready_o,

  // requests to the east
  output mc_req_s                   req_o,
  output logic                      req_v_o,
  input  logic                      req_ready_i,

  // requests to the local bank
  output mc_req_s                   eject_o,
  output logic                      eject_v_o,
  input  logic                      eject_ready_i,

  // responses from the local bank
  input  mc_resp_s                  bank_resp_i,
  input  logic                      bank_resp_v_i,
  output logic                      bank_resp_ready_o,

  // responses from the east
  input  mc_resp_s                  east_resp_i,
  input  logic                      east_resp_v_i,
  output logic                      east_resp_ready_o,

  // responses to the west
  output mc_resp_s                  resp_o,
  output logic                      resp_v_o,
  input  logic                      resp_ready_i
);

  mc_req_s  req_r;
  logic     req_full_r;
  logic     is_local;
  logic     req_in_fire;
  logic     req_out_fire;

  mc_resp_s resp_r;
  logic     resp_full_r;
  logic     resp_load_ok;
  logic     resp_in_fire;
  logic     resp_out_fire;

  // request side
  assign is_local = (req_r.addr[x_cord_width_c-1:0] == my_x_i);

  assign req_o     = req_r;
  assign eject_o   = req_r;
  assign req_v_o   = req_full_r & ~is_local;
  assign eject_v_o = req_full_r & is_local;

  assign req_out_fire = (req_v_o & req_ready_i) | (eject_v_o & eject_ready_i);
  // accept while draining so the stage runs at full rate
  assign req_ready_o  = ~req_full_r | req_out_fire;
  assign req_in_fire  = req_v_i & req_ready_o;

  always_ff @(posedge clk) begin
    if (!reset) begin
      req_full_r <= 1'b0;
    end else if (req_in_fire) begin
      req_full_r <= 1'b1;
    end else if (req_out_fire) begin
      req_full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_in_fire) begin
      req_r <= req_i;
    end
  end

  // response side, local bank has priority
  assign resp_o   = resp_r;
  assign resp_v_o = resp_full_r;

  assign resp_out_fire     = resp_full_r & resp_ready_i;
  assign resp_load_ok      = ~resp_full_r | resp_out_fire;
  assign bank_resp_ready_o = resp_load_ok;
  assign east_resp_ready_o = resp_load_ok & ~bank_resp_v_i;
  assign resp_in_fire      = (bank_resp_v_i | east_resp_v_i) & resp_load_ok;

  always_ff @(posedge clk) begin
    if (!reset) begin
      resp_full_r <= 1'b0;
    end else if (resp_in_fire) begin
      resp_full_r <= 1'b1;
    end else if (resp_out_fire) begin
      resp_full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_in_fire) begin
      resp_r <= bank_resp_v_i ? bank_resp_i : east_resp_i;
    end
  end

endmodule

`default_nettype wire

//--- mc_pkg.sv
// shared definitions for the row memory system
// geometry and sizing constants, link opcodes,
// request, response and memory request packets

`default_nettype none

package mc_pkg;

  // row geometry
  localparam int num_tiles_x_c = 4;
  localparam int x_cord_width_c = 2;

  // word and address sizes
  localparam int data_width_c = 32;
  localparam int addr_width_c = 12;
  // bank-local address, low bits of addr pick the column
  localparam int local_addr_width_c = addr_width_c - x_cord_width_c;
  localparam int mem_words_c = 1 << addr_width_c;

  // vcache geometry, one word per line
  localparam int cache_sets_c = 16;
  localparam int index_width_c = $clog2(cache_sets_c);
  localparam int tag_width_c = 6;
  localparam int stat_cnt_width_c = 16;

  localparam int tag_id_width_c = 4;

  // dram timing
  localparam int dram_latency_c = 4;
  localparam int dram_cnt_width_c = $clog2(dram_latency_c);

  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1,
    op_stat  = 2'd2
  } mc_op_e;

  // host to bank
  typedef struct packed {
    mc_op_e                    op;
    logic [addr_width_c-1:0]   addr;
    logic [data_width_c-1:0]   data;
    logic [tag_id_width_c-1:0] tag_id;
  } mc_req_s;

  // bank to host
  typedef struct packed {
    mc_op_e                    op;
    logic [data_width_c-1:0]   data;
    logic [tag_id_width_c-1:0] tag_id;
    logic                      hit;
    logic [x_cord_width_c-1:0] src_x;
  } mc_resp_s;

  // bank to dram, addr is bank-local
  typedef struct packed {
    logic                          write;
    logic [local_addr_width_c-1:0] addr;
    logic [data_width_c-1:0]       data;
  } mem_req_s;

endpackage

`default_nettype wire
